// ==== sim.f ====
+incdir+common
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
execute/rv_alu.sv
execute/rv_branch_unit.sv
logic/rv_pc_control.sv
logic/rv_core.sv
sim/tb_rv_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_rv_core -Mdir obj_dir
	./obj_dir/Vtb_rv_core | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ns

`include "rv_consts.svh"

module tb_rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
();

  localparam logic [31:0] SEED = 32'ha3a0e60a;
  localparam int N_INSNS   = 300;  // Last one is the ECALL
  localparam int GAP_PCT   = 20;   // Chance of an idle cycle before an instruction
  localparam int MAX_GAP   = 4;
  localparam int WORST_GAP = MAX_GAP + 1;
  localparam int TAIL      = 6;    // Cycles of valid held high after the halt
  localparam int WATCHDOG_CYCLES = 2 * N_INSNS * WORST_GAP;
  localparam insn_t ECALL_INSN = 32'h0000_0073;

  logic    clk;
  logic    rst;
  logic    insn_valid;
  logic    insn_ready;
  insn_t   insn;
  word_t   pc_to_imem;
  retire_t retire;
  logic    halt;

  // Reference state, owned by the stimulus
  word_t   model_regs [32];
  word_t   model_pc;
  retire_t pending_rec;
  logic    pending;       // An accept happens on the coming edge
  logic    pending_halt;
  int      errors  = 0;
  int      checks  = 0;
  int      retired = 0;

  rv_core uut (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn_ready (insn_ready),
    .insn       (insn),
    .pc_to_imem (pc_to_imem),
    .retire     (retire),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic reg_idx_t pick_reg();
    if ($urandom_range(0, 3) != 0)
      return 5'($urandom_range(0, 7));  // Small set, so results feed later operands
    return 5'($urandom_range(0, 31));
  endfunction

  // Random legal instruction from the kept RV32I subset
  function automatic insn_t random_insn();
    insn_t w;
    int    kind;
    w = $urandom();
    w[11:7]  = pick_reg();
    w[19:15] = pick_reg();
    kind = $urandom_range(0, 9);
    case (kind)
      0, 1: begin
        w[6:0] = OPC_OP_IMM;
        if (w[14:12] == 3'b001)
          w[31:25] = 7'b0;
        else if (w[14:12] == 3'b101)
          w[31:25] = {1'b0, w[30], 5'b0};  // SRLI or SRAI
      end
      2, 3: begin
        w[6:0]   = OPC_OP;
        w[24:20] = pick_reg();
        w[31:25] = (w[14:12] == 3'b000 || w[14:12] == 3'b101) ? {1'b0, w[30], 5'b0} : 7'b0;
      end
      4: w[6:0] = OPC_LUI;
      5: w[6:0] = OPC_AUIPC;
      6, 7: begin
        w[6:0]   = OPC_BRANCH;
        w[24:20] = pick_reg();
        if (w[13] && !w[14])
          w[14] = 1'b1;  // Codes 2 and 3 are not branches
      end
      8: w[6:0] = OPC_JAL;
      default: begin
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'b000;
        w[20]    = 1'b0;  // Even offset
      end
    endcase
    return w;
  endfunction

  function automatic word_t arith_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic retire_t expected_retire(insn_t ins, word_t cur_pc);
    retire_t r;
    word_t   a;
    word_t   b;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_u;
    logic    taken;
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    r         = '0;
    r.valid   = 1'b1;
    r.pc      = cur_pc;
    r.rd      = ins[11:7];
    r.next_pc = cur_pc + `RV_INSN_STEP;
    case (ins[6:0])
      OPC_LUI: begin
        r.rd_we   = 1'b1;
        r.rd_data = imm_u;
      end
      OPC_AUIPC: begin
        r.rd_we   = 1'b1;
        r.rd_data = cur_pc + imm_u;
      end
      OPC_OP_IMM: begin
        r.rd_we   = 1'b1;
        r.rd_data = arith_ref(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
      end
      OPC_OP: begin
        r.rd_we   = 1'b1;
        r.rd_data = arith_ref(ins[14:12], ins[30], a, b);
      end
      OPC_BRANCH: begin
        case (ins[14:12])
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken)
          r.next_pc = cur_pc + imm_b;
      end
      OPC_JAL: begin
        r.rd_we   = 1'b1;
        r.rd_data = cur_pc + `RV_INSN_STEP;
        r.next_pc = cur_pc + imm_j;
      end
      OPC_JALR: begin
        r.rd_we   = 1'b1;
        r.rd_data = cur_pc + `RV_INSN_STEP;
        r.next_pc = (a + imm_i) & ~32'h1;
      end
      default: ;  // ECALL writes nothing
    endcase
    return r;
  endfunction

  task automatic note_mismatch(string what, word_t got, word_t expected);
    errors++;
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
  endtask

  initial begin
    insn_t   next_insn;
    retire_t rec;
    int      gap;
    void'($urandom(SEED));
    rst          = 1'b1;
    insn_valid   = 1'b0;
    insn         = '0;
    pending      = 1'b0;
    pending_halt = 1'b0;
    pending_rec  = '0;
    model_pc     = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < N_INSNS; n++) begin
      gap = 0;
      while (gap < MAX_GAP && $urandom_range(0, 99) < GAP_PCT) begin
        insn_valid = 1'b0;
        insn       = random_insn();  // Must be ignored while invalid
        gap++;
        @(negedge clk);
      end
      next_insn  = (n == N_INSNS - 1) ? ECALL_INSN : random_insn();
      insn       = next_insn;
      insn_valid = 1'b1;
      while (!insn_ready) @(negedge clk);
      rec = expected_retire(next_insn, model_pc);
      if (rec.rd_we && rec.rd != '0)
        model_regs[rec.rd] = rec.rd_data;
      model_pc     = rec.next_pc;
      pending_rec  = rec;
      pending_halt = (next_insn == ECALL_INSN);
      pending      = 1'b1;
      @(negedge clk);
    end
    // Halted core must leave this one pending
    insn       = random_insn();
    insn_valid = 1'b1;
    repeat (TAIL) @(negedge clk);
    insn_valid = 1'b0;
    @(negedge clk);
    $display("Retired %0d, check cycles %0d, errors %0d", retired, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Checks one ns after each rising edge, while the outputs are settled
  initial begin
    logic    exp_valid;
    retire_t exp_rec;
    logic    halted_exp;
    halted_exp = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      exp_valid = pending;
      exp_rec   = pending_rec;
      pending   = 1'b0;
      checks++;
      assert (retire.valid == exp_valid)
        else note_mismatch("retire.valid", word_t'(retire.valid), word_t'(exp_valid));
      if (exp_valid && retire.valid) begin
        retired++;
        assert (retire.pc == exp_rec.pc)
          else note_mismatch("retire.pc", retire.pc, exp_rec.pc);
        assert (retire.rd_we == exp_rec.rd_we)
          else note_mismatch("retire.rd_we", word_t'(retire.rd_we), word_t'(exp_rec.rd_we));
        if (exp_rec.rd_we) begin
          assert (retire.rd == exp_rec.rd)
            else note_mismatch("retire.rd", word_t'(retire.rd), word_t'(exp_rec.rd));
          assert (retire.rd_data == exp_rec.rd_data)
            else note_mismatch("retire.rd_data", retire.rd_data, exp_rec.rd_data);
        end
        assert (retire.next_pc == exp_rec.next_pc)
          else note_mismatch("retire.next_pc", retire.next_pc, exp_rec.next_pc);
        if (pending_halt)
          halted_exp = 1'b1;
      end
      assert (pc_to_imem == model_pc)
        else note_mismatch("pc_to_imem", pc_to_imem, model_pc);
      assert (halt == halted_exp)
        else note_mismatch("halt", word_t'(halt), word_t'(halted_exp));
      assert (insn_ready == !halted_exp)
        else note_mismatch("insn_ready", word_t'(insn_ready), word_t'(!halted_exp));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the stream finished", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ns

module rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    insn_valid,
  output logic    insn_ready,
  input  insn_t   insn,
  output word_t   pc_to_imem,
  output retire_t retire,
  output logic    halt
);

  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;
  alu_out_t alu_out;
  br_out_t  br_out;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (dec.rs1),
    .rs2_idx  (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_data  (wr_data)
  );

  // ALU and branch unit see the same operands in parallel
  rv_alu u_alu (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc_to_imem),
    .alu_out  (alu_out)
  );

  rv_branch_unit u_branch (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc_to_imem),
    .br_out   (br_out)
  );

  rv_pc_control u_pc_control (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn_ready (insn_ready),
    .dec        (dec),
    .alu_out    (alu_out),
    .br_out     (br_out),
    .pc         (pc_to_imem),  // Current PC doubles as the fetch address
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_data    (wr_data),
    .retire     (retire),
    .halt       (halt)
  );

endmodule

// ==== logic/rv_pc_control.sv ====
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_pc_control
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     insn_valid,
  output logic     insn_ready,
  input  decoded_t dec,
  input  alu_out_t alu_out,
  input  br_out_t  br_out,
  output word_t    pc,
  output logic     wr_en,
  output reg_idx_t wr_idx,
  output word_t    wr_data,
  output retire_t  retire,
  output logic     halt
);

  core_state_e state;
  logic        accept;
  word_t       next_pc;
  word_t       wb_data;

  assign insn_ready = (state == ST_RUN);
  assign halt       = (state == ST_HALTED);
  assign accept     = insn_valid && insn_ready;

  // Jumps write the link, all else the ALU result
  assign wb_data = (dec.br_kind inside {BR_JAL, BR_JALR}) ? br_out.link : alu_out.result;
  assign next_pc = br_out.redirect ? br_out.target : pc + `RV_INSN_STEP;

  assign wr_en   = accept && dec.rd_we;
  assign wr_idx  = dec.rd;
  assign wr_data = wb_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= `RV_RESET_PC;
      state        <= ST_RUN;
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= accept;  // One cycle per accepted instruction
      if (accept) begin
        pc             <= next_pc;
        retire.pc      <= pc;
        retire.rd      <= dec.rd;
        retire.rd_we   <= dec.rd_we;
        retire.rd_data <= wb_data;
        retire.next_pc <= next_pc;
        if (dec.is_halt)
          state <= ST_HALTED;  // Sticky until reset
      end
    end
  end

  // Once halted the core never leaves HALTED and never retires again
  a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
    (state == ST_HALTED) |=> (state == ST_HALTED) && !retire.valid);

  a_pc_even: assert property (@(posedge clk) disable iff (rst) !pc[0]);

endmodule

// ==== execute/rv_branch_unit.sv ====
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_branch_unit
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  decoded_t dec,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    pc,
  output br_out_t  br_out
);

  logic  taken;
  word_t base;
  word_t sum;

  always_comb begin
    case (dec.cond)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // JALR is register relative, everything else PC relative
  assign base = (dec.br_kind == BR_JALR) ? rs1_data : pc;
  assign sum  = base + dec.imm;

  assign br_out.target = (dec.br_kind == BR_JALR) ? {sum[`RV_XLEN-1:1], 1'b0} : sum;
  assign br_out.link   = pc + `RV_INSN_STEP;

  always_comb begin
    case (dec.br_kind)
      BR_COND: br_out.redirect = taken;
      BR_JAL,
      BR_JALR: br_out.redirect = 1'b1;
      default: br_out.redirect = 1'b0;
    endcase
  end

endmodule

// ==== execute/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  decoded_t dec,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    pc,
  output alu_out_t alu_out
);

  word_t      op_b;
  logic [4:0] shamt;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];  // Only the low 5 bits shift a 32-bit word

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_out.result = rs1_data + op_b;
      ALU_SUB:    alu_out.result = rs1_data - op_b;
      ALU_SLL:    alu_out.result = rs1_data << shamt;
      ALU_SLT:    alu_out.result = word_t'($signed(rs1_data) < $signed(op_b));
      ALU_SLTU:   alu_out.result = word_t'(rs1_data < op_b);
      ALU_XOR:    alu_out.result = rs1_data ^ op_b;
      ALU_SRL:    alu_out.result = rs1_data >> shamt;
      ALU_SRA:    alu_out.result = $signed(rs1_data) >>> shamt;
      ALU_OR:     alu_out.result = rs1_data | op_b;
      ALU_AND:    alu_out.result = rs1_data & op_b;
      ALU_PASS_B: alu_out.result = op_b;       // LUI
      ALU_PC_ADD: alu_out.result = pc + op_b;  // AUIPC
      default:    alu_out.result = '0;
    endcase
  end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_regfile
  import rv_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data
);

  word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin  // x0 is never written
      regs[wr_idx] <= wr_data;
    end
  end

  // Combinational reads, x0 comes back as its cleared entry
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  insn_t    insn,
  output decoded_t dec
);

  opcode_e opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;
  logic    is_shift;
  logic    alt_ok;

  function automatic alu_op_e arith_op(funct3_t f3, logic alt);
    alu_op_e op;
    op = ALU_ADD;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // Immediates, all sign-extended from insn[31]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SR);
  // ADDI has no alternate form, its funct7 bits belong to the immediate
  assign alt_ok = (funct7 == F7_ALT) &&
                  ((funct3 == F3_SR) || (funct3 == F3_ADD && opcode == OPC_OP));

  always_comb begin
    dec         = '0;
    dec.rd      = insn[11:7];
    dec.rs1     = insn[19:15];
    dec.rs2     = insn[24:20];
    dec.cond    = funct3;
    dec.alu_op  = ALU_ADD;
    dec.br_kind = BR_NONE;
    case (opcode)
      OPC_LUI: begin
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PC_ADD;
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.alu_op  = arith_op(funct3, alt_ok);
        dec.rd_we   = !is_shift || (funct7 == F7_BASE) || alt_ok;
      end
      OPC_OP: begin
        dec.alu_op = arith_op(funct3, alt_ok);
        dec.rd_we  = (funct7 == F7_BASE) || alt_ok;  // M extension falls out here
      end
      OPC_BRANCH: begin
        dec.imm = imm_b;
        if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU})
          dec.br_kind = BR_COND;
      end
      OPC_JAL: begin
        dec.imm     = imm_j;
        dec.br_kind = BR_JAL;
        dec.rd_we   = 1'b1;
      end
      OPC_JALR: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        if (funct3 == '0) begin
          dec.br_kind = BR_JALR;
          dec.rd_we   = 1'b1;
        end
      end
      OPC_SYSTEM: dec.is_halt = (insn[31:7] == '0);  // ECALL only
      default: ;  // Loads, stores, fences retire as no-ops
    endcase
  end

endmodule

// ==== common/rv_core_pkg.sv ====
`include "rv_consts.svh"

package rv_core_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,  // LUI
    ALU_PC_ADD   // AUIPC
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_COND,
    BR_JAL,
    BR_JALR
  } br_kind_e;

  typedef struct packed {
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;   // Operand B from imm instead of rs2
    logic     rd_we;
    logic     is_halt;   // ECALL
    br_kind_e br_kind;
    funct3_t  cond;
  } decoded_t;

  typedef struct packed {
    word_t result;
  } alu_out_t;

  typedef struct packed {
    logic  redirect;
    word_t target;
    word_t link;
  } br_out_t;

  // One record per retired instruction
  typedef struct packed {
    logic     valid;
    word_t    pc;
    reg_idx_t rd;
    logic     rd_we;
    word_t    rd_data;
    word_t    next_pc;
  } retire_t;

  typedef enum logic {
    ST_RUN,
    ST_HALTED
  } core_state_e;

endpackage

// ==== common/rv_isa_pkg.sv ====
`include "rv_consts.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [31:0] insn_t;  // RV32I encodings are always 32 bits
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Major opcodes of the base ISA
  typedef enum logic [`RV_OPCODE_W-1:0] {
    OPC_LOAD     = 7'b00_000_11,
    OPC_STORE    = 7'b01_000_11,
    OPC_BRANCH   = 7'b11_000_11,
    OPC_JALR     = 7'b11_001_11,
    OPC_MISC_MEM = 7'b00_011_11,
    OPC_JAL      = 7'b11_011_11,
    OPC_OP_IMM   = 7'b00_100_11,
    OPC_OP       = 7'b01_100_11,
    OPC_SYSTEM   = 7'b11_100_11,
    OPC_AUIPC    = 7'b00_101_11,
    OPC_LUI      = 7'b01_101_11
  } opcode_e;

  // Arithmetic funct3, shared by OP and OP_IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // SRL or SRA, picked by funct7
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct7_t F7_BASE = 7'b000_0000;
  localparam funct7_t F7_ALT  = 7'b010_0000;  // SUB, SRA, SRAI

endpackage

// ==== common/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Register and datapath width
`define RV_XLEN 32

// Register file geometry
`define RV_NUM_REGS 32
`define RV_REG_IDX_W 5

// Major opcode field, insn[6:0]
`define RV_OPCODE_W 7

// Sequential PC increment in bytes
`define RV_INSN_STEP 4

`define RV_RESET_PC 32'h0000_0000  // First fetch address

`endif
